/* mci_csr.sv */
// Read and write strobes must never coincide and read data returns one cycle after the strobe
`timescale 1ns/1ps

module mci_csr (
    input  logic                clk,
    input  logic                rst_i,

    // Register port
    input  logic                csr_wr_i,
    input  logic                csr_rd_i,
    input  mci_pkg::csr_addr_t  csr_addr_i,
    input  mci_pkg::csr_data_t  csr_wdata_i,
    output logic                csr_rvalid_o,
    output mci_pkg::csr_data_t  csr_rdata_o,

    // Status from the watchdog and the aggregator
    input  mci_pkg::wdt_sts_t   wdt_sts_i,
    input  mci_pkg::err_sts_t   err_sts_i,

    // Configuration and pulses out
    output mci_pkg::wdt_cfg_t   wdt_cfg_o,
    output mci_pkg::intr_cfg_t  intr_cfg_o,
    output mci_pkg::err_vec_t   fatal_clr_o,
    output mci_pkg::err_vec_t   nonfatal_clr_o
);

    import mci_pkg::*;

    wdt_cfg_t  wdt_cfg_q;
    intr_cfg_t intr_cfg_q;
    err_vec_t  fatal_clr_q;
    err_vec_t  nonfatal_clr_q;
    csr_data_t rdata_d;
    csr_data_t rdata_q;
    logic      rvalid_q;

    //////////////////////////////////////////////////
    // Write decode
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wdt_cfg_q      <= '0;
            intr_cfg_q     <= '0;
            fatal_clr_q    <= '0;
            nonfatal_clr_q <= '0;
        end else begin
            // Restart and W1C clears last a single cycle
            wdt_cfg_q.restart <= 1'b0;
            fatal_clr_q       <= '0;
            nonfatal_clr_q    <= '0;
            if (csr_wr_i) begin
                case (csr_addr_i)
                    ADDR_WDT_CTRL:          wdt_cfg_q.t1_en          <= csr_wdata_i[0];
                    ADDR_WDT_RESTART:       wdt_cfg_q.restart        <= 1'b1;
                    ADDR_WDT_T1_PERIOD:     wdt_cfg_q.t1_period      <= csr_wdata_i;
                    ADDR_WDT_T2_PERIOD:     wdt_cfg_q.t2_period      <= csr_wdata_i;
                    ADDR_ERR_FATAL_STS:     fatal_clr_q              <= csr_wdata_i;
                    ADDR_ERR_NONFATAL_STS:  nonfatal_clr_q           <= csr_wdata_i;
                    ADDR_ERR_FATAL_MASK:    intr_cfg_q.fatal_mask    <= csr_wdata_i;
                    ADDR_ERR_NONFATAL_MASK: intr_cfg_q.nonfatal_mask <= csr_wdata_i;
                    ADDR_INTR_EN: begin
                        intr_cfg_q.wdt_intr_en      <= csr_wdata_i[0];
                        intr_cfg_q.nonfatal_intr_en <= csr_wdata_i[1];
                        intr_cfg_q.global_intr_en   <= csr_wdata_i[2];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Read return
    //////////////////////////////////////////////////

    always_comb begin
        rdata_d = '0;
        case (csr_addr_i)
            ADDR_WDT_CTRL:          rdata_d = {31'd0, wdt_cfg_q.t1_en};
            ADDR_WDT_T1_PERIOD:     rdata_d = wdt_cfg_q.t1_period;
            ADDR_WDT_T2_PERIOD:     rdata_d = wdt_cfg_q.t2_period;
            ADDR_ERR_FATAL_STS:     rdata_d = err_sts_i.fatal;
            ADDR_ERR_NONFATAL_STS:  rdata_d = err_sts_i.nonfatal;
            ADDR_ERR_FATAL_MASK:    rdata_d = intr_cfg_q.fatal_mask;
            ADDR_ERR_NONFATAL_MASK: rdata_d = intr_cfg_q.nonfatal_mask;
            ADDR_INTR_EN: begin
                rdata_d = {29'd0, intr_cfg_q.global_intr_en,
                           intr_cfg_q.nonfatal_intr_en, intr_cfg_q.wdt_intr_en};
            end
            ADDR_WDT_STS: rdata_d = {30'd0, wdt_sts_i.fatal_timeout, wdt_sts_i.t1_timeout};
            // Restart is write only and unmapped words read zero
            default:      rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
        end else begin
            rvalid_q <= csr_rd_i;
            if (csr_rd_i) begin
                rdata_q <= rdata_d;
            end
        end
    end

    assign csr_rvalid_o   = rvalid_q;
    assign csr_rdata_o    = rdata_q;
    assign wdt_cfg_o      = wdt_cfg_q;
    assign intr_cfg_o     = intr_cfg_q;
    assign fatal_clr_o    = fatal_clr_q;
    assign nonfatal_clr_o = nonfatal_clr_q;

    // Single-ported register file
    a_no_rd_wr_overlap: assert property (
        @(posedge clk) disable iff (rst_i) !(csr_wr_i && csr_rd_i)
    );

endmodule

/* mci_err_agg.sv */
// NUM_ERR must lie in 1 to 32 and error inputs at or above it are ignored
`timescale 1ns/1ps

module mci_err_agg #(
    parameter int unsigned NUM_ERR = 32
) (
    input  logic              clk,
    input  logic              rst_i,

    // Subsystem error wires
    input  mci_pkg::err_vec_t agg_error_fatal_i,
    input  mci_pkg::err_vec_t agg_error_non_fatal_i,

    // W1C pulses from the register file
    input  mci_pkg::err_vec_t fatal_clr_i,
    input  mci_pkg::err_vec_t nonfatal_clr_i,

    output mci_pkg::err_sts_t err_sts_o
);

    import mci_pkg::*;

    localparam err_vec_t ERR_VALID = err_valid_mask(NUM_ERR);

    err_vec_t fatal_q;
    err_vec_t nonfatal_q;

    // New error beats a clear in the same cycle
    function automatic err_vec_t sticky_next(
        input err_vec_t cur,
        input err_vec_t set,
        input err_vec_t clr
    );
        return ((cur & ~clr) | set) & ERR_VALID;
    endfunction

    //////////////////////////////////////////////////
    // Sticky status
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fatal_q    <= '0;
            nonfatal_q <= '0;
        end else begin
            fatal_q    <= sticky_next(fatal_q, agg_error_fatal_i, fatal_clr_i);
            nonfatal_q <= sticky_next(nonfatal_q, agg_error_non_fatal_i, nonfatal_clr_i);
        end
    end

    assign err_sts_o.fatal    = fatal_q;
    assign err_sts_o.nonfatal = nonfatal_q;

    // Unused sources never show up in status
    a_upper_bits_zero: assert property (
        @(posedge clk) disable iff (rst_i)
        ((err_sts_o.fatal | err_sts_o.nonfatal) & ~ERR_VALID) == '0
    );

endmodule

/* mci_intr_comb.sv */
// All outputs are registered and lag the status by one cycle
`timescale 1ns/1ps

module mci_intr_comb #(
    parameter int unsigned NUM_ERR = 32
) (
    input  logic               clk,
    input  logic               rst_i,
    input  mci_pkg::err_sts_t  err_sts_i,
    input  mci_pkg::wdt_sts_t  wdt_sts_i,
    input  mci_pkg::intr_cfg_t intr_cfg_i,
    output logic               all_error_fatal_o,
    output logic               all_error_non_fatal_o,
    output logic               mci_intr_o,
    output logic               nmi_intr_o
);

    import mci_pkg::*;

    localparam err_vec_t ERR_VALID = err_valid_mask(NUM_ERR);

    err_vec_t fatal_unmasked;
    err_vec_t nonfatal_unmasked;
    logic     fatal_d;
    logic     nonfatal_d;
    logic     intr_d;

    assign fatal_unmasked    = err_sts_i.fatal & ~intr_cfg_i.fatal_mask & ERR_VALID;
    assign nonfatal_unmasked = err_sts_i.nonfatal & ~intr_cfg_i.nonfatal_mask & ERR_VALID;

    // Watchdog fatal timeout cannot be masked
    assign fatal_d    = (|fatal_unmasked) | wdt_sts_i.fatal_timeout;
    assign nonfatal_d = |nonfatal_unmasked;

    assign intr_d = intr_cfg_i.global_intr_en &
                    ((wdt_sts_i.t1_timeout & intr_cfg_i.wdt_intr_en) |
                     (nonfatal_d & intr_cfg_i.nonfatal_intr_en));

    //////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            all_error_fatal_o     <= 1'b0;
            all_error_non_fatal_o <= 1'b0;
            mci_intr_o            <= 1'b0;
            nmi_intr_o            <= 1'b0;
        end else begin
            all_error_fatal_o     <= fatal_d;
            all_error_non_fatal_o <= nonfatal_d;
            mci_intr_o            <= intr_d;
            nmi_intr_o            <= wdt_sts_i.fatal_timeout;
        end
    end

    // NMI is always accompanied by the SoC fatal error
    a_nmi_is_fatal: assert property (
        @(posedge clk) disable iff (rst_i) nmi_intr_o |-> all_error_fatal_o
    );

endmodule

/* mci_pkg.sv */
// Register map and field layouts assume a 32-bit data bus and no more than 32 error sources
package mci_pkg;

    //////////////////////////////////////////////////
    // Widths and vector types
    //////////////////////////////////////////////////

    localparam int unsigned CSR_ADDR_W   = 4;
    localparam int unsigned CSR_DATA_W   = 32;
    localparam int unsigned ERR_W        = 32;
    localparam int unsigned WDT_PERIOD_W = 32;

    typedef logic [CSR_ADDR_W-1:0]   csr_addr_t;
    typedef logic [CSR_DATA_W-1:0]   csr_data_t;
    typedef logic [ERR_W-1:0]        err_vec_t;
    typedef logic [WDT_PERIOD_W-1:0] wdt_period_t;

    //////////////////////////////////////////////////
    // Register word addresses
    //////////////////////////////////////////////////

    localparam csr_addr_t ADDR_WDT_CTRL          = 4'd0;
    localparam csr_addr_t ADDR_WDT_RESTART       = 4'd1;
    localparam csr_addr_t ADDR_WDT_T1_PERIOD     = 4'd2;
    localparam csr_addr_t ADDR_WDT_T2_PERIOD     = 4'd3;
    localparam csr_addr_t ADDR_ERR_FATAL_STS     = 4'd4;
    localparam csr_addr_t ADDR_ERR_NONFATAL_STS  = 4'd5;
    localparam csr_addr_t ADDR_ERR_FATAL_MASK    = 4'd6;
    localparam csr_addr_t ADDR_ERR_NONFATAL_MASK = 4'd7;
    localparam csr_addr_t ADDR_INTR_EN           = 4'd8;
    localparam csr_addr_t ADDR_WDT_STS           = 4'd9;

    //////////////////////////////////////////////////
    // Grouped configuration and status
    //////////////////////////////////////////////////

    typedef struct packed {
        logic        t1_en;
        logic        restart;
        wdt_period_t t1_period;
        wdt_period_t t2_period;
    } wdt_cfg_t;

    // WDT_STS reads back as {fatal_timeout, t1_timeout} in bits 1:0
    typedef struct packed {
        logic fatal_timeout;
        logic t1_timeout;
    } wdt_sts_t;

    // Set mask bit suppresses that source at the outputs
    typedef struct packed {
        err_vec_t fatal_mask;
        err_vec_t nonfatal_mask;
        logic     global_intr_en;
        logic     nonfatal_intr_en;
        logic     wdt_intr_en;
    } intr_cfg_t;

    typedef struct packed {
        err_vec_t fatal;
        err_vec_t nonfatal;
    } err_sts_t;

    // Ones in the low num_err bits
    function automatic err_vec_t err_valid_mask(input int unsigned num_err);
        return err_vec_t'((64'd1 << num_err) - 64'd1);
    endfunction

endpackage

/* mci_top.sv */
// No back-pressure on the register port and NUM_ERR must lie in 1 to 32
`timescale 1ns/1ps

module mci_top #(
    parameter int unsigned NUM_ERR       = 32,
    parameter int unsigned WDT_CNT_WIDTH = 32
) (
    input  logic               clk,
    input  logic               rst_i,

    // Register port
    input  logic               csr_wr_i,
    input  logic               csr_rd_i,
    input  mci_pkg::csr_addr_t csr_addr_i,
    input  mci_pkg::csr_data_t csr_wdata_i,
    output logic               csr_rvalid_o,
    output mci_pkg::csr_data_t csr_rdata_o,

    // Subsystem error wires
    input  mci_pkg::err_vec_t  agg_error_fatal_i,
    input  mci_pkg::err_vec_t  agg_error_non_fatal_i,

    // SoC and MCU outputs
    output logic               all_error_fatal_o,
    output logic               all_error_non_fatal_o,
    output logic               mci_intr_o,
    output logic               nmi_intr_o
);

    import mci_pkg::*;

    wdt_cfg_t  wdt_cfg;
    intr_cfg_t intr_cfg;
    wdt_sts_t  wdt_sts;
    err_sts_t  err_sts;
    err_vec_t  fatal_clr;
    err_vec_t  nonfatal_clr;

    mci_csr i_mci_csr (
        .clk            (clk),
        .rst_i          (rst_i),
        .csr_wr_i       (csr_wr_i),
        .csr_rd_i       (csr_rd_i),
        .csr_addr_i     (csr_addr_i),
        .csr_wdata_i    (csr_wdata_i),
        .csr_rvalid_o   (csr_rvalid_o),
        .csr_rdata_o    (csr_rdata_o),
        .wdt_sts_i      (wdt_sts),
        .err_sts_i      (err_sts),
        .wdt_cfg_o      (wdt_cfg),
        .intr_cfg_o     (intr_cfg),
        .fatal_clr_o    (fatal_clr),
        .nonfatal_clr_o (nonfatal_clr)
    );

    mci_wdt #(
        .WDT_CNT_WIDTH (WDT_CNT_WIDTH)
    ) i_mci_wdt (
        .clk       (clk),
        .rst_i     (rst_i),
        .wdt_cfg_i (wdt_cfg),
        .wdt_sts_o (wdt_sts)
    );

    mci_err_agg #(
        .NUM_ERR (NUM_ERR)
    ) i_mci_err_agg (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .agg_error_fatal_i     (agg_error_fatal_i),
        .agg_error_non_fatal_i (agg_error_non_fatal_i),
        .fatal_clr_i           (fatal_clr),
        .nonfatal_clr_i        (nonfatal_clr),
        .err_sts_o             (err_sts)
    );

    mci_intr_comb #(
        .NUM_ERR (NUM_ERR)
    ) i_mci_intr_comb (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .err_sts_i             (err_sts),
        .wdt_sts_i             (wdt_sts),
        .intr_cfg_i            (intr_cfg),
        .all_error_fatal_o     (all_error_fatal_o),
        .all_error_non_fatal_o (all_error_non_fatal_o),
        .mci_intr_o            (mci_intr_o),
        .nmi_intr_o            (nmi_intr_o)
    );

endmodule

/* mci_wdt.sv */
// WDT_CNT_WIDTH must not exceed 32 and period bits above it are ignored
`timescale 1ns/1ps

module mci_wdt #(
    parameter int unsigned WDT_CNT_WIDTH = 32
) (
    input  logic              clk,
    input  logic              rst_i,
    input  mci_pkg::wdt_cfg_t wdt_cfg_i,
    output mci_pkg::wdt_sts_t wdt_sts_o
);

    // Stage two means the first timeout has fired
    typedef enum logic {
        STAGE_ONE,
        STAGE_TWO
    } wdt_stage_e;

    wdt_stage_e               stage_q;
    logic [WDT_CNT_WIDTH-1:0] t1_cnt_q;
    logic [WDT_CNT_WIDTH-1:0] t2_cnt_q;
    logic [WDT_CNT_WIDTH-1:0] t1_limit;
    logic [WDT_CNT_WIDTH-1:0] t2_limit;
    logic                     t1_hit;
    logic                     t2_hit;
    logic                     fatal_q;

    assign t1_limit = wdt_cfg_i.t1_period[WDT_CNT_WIDTH-1:0];
    assign t2_limit = wdt_cfg_i.t2_period[WDT_CNT_WIDTH-1:0];

    // Compare with >= so a period lowered under a running count still expires
    assign t1_hit = (t1_cnt_q >= t1_limit);
    assign t2_hit = (t2_cnt_q >= t2_limit);

    //////////////////////////////////////////////////
    // Cascaded timers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            stage_q  <= STAGE_ONE;
            t1_cnt_q <= '0;
            t2_cnt_q <= '0;
            fatal_q  <= 1'b0;
        end else if (wdt_cfg_i.restart) begin
            // Fatal timeout survives a restart
            stage_q  <= STAGE_ONE;
            t1_cnt_q <= '0;
            t2_cnt_q <= '0;
        end else begin
            case (stage_q)
                STAGE_ONE: begin
                    if (wdt_cfg_i.t1_en) begin
                        if (t1_hit) begin
                            stage_q <= STAGE_TWO;
                        end else begin
                            t1_cnt_q <= t1_cnt_q + 1'b1;
                        end
                    end
                end
                STAGE_TWO: begin
                    // Timer 2 runs without an enable of its own
                    if (!fatal_q) begin
                        if (t2_hit) begin
                            fatal_q <= 1'b1;
                        end else begin
                            t2_cnt_q <= t2_cnt_q + 1'b1;
                        end
                    end
                end
                default: begin
                    stage_q <= STAGE_ONE;
                end
            endcase
        end
    end

    assign wdt_sts_o.t1_timeout    = (stage_q == STAGE_TWO);
    assign wdt_sts_o.fatal_timeout = fatal_q;

    // Timer 2 holds at zero until the first stage has fired
    a_t2_idle_in_stage_one: assert property (
        @(posedge clk) disable iff (rst_i)
        (stage_q == STAGE_ONE) |=> (t2_cnt_q == '0)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator, then searches the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mci_top -f verilog.f \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_mci_top > sim.log 2>&1 || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation FAILED"; exit 1; }
echo "Simulation passed"
exit 0

/* tb_mci_checker.sv */
// Samples DUT outputs on the falling clock edge and expects check_i high for one negedge per row
`timescale 1ns/1ps

module tb_mci_checker (
    input  logic               clk,
    input  logic               rst_i,

    // Read strobe as driven to the DUT
    input  logic               csr_rd_i,

    // DUT outputs under watch
    input  logic               csr_rvalid_i,
    input  mci_pkg::csr_data_t csr_rdata_i,
    input  logic               all_error_fatal_i,
    input  logic               all_error_non_fatal_i,
    input  logic               mci_intr_i,
    input  logic               nmi_intr_i,

    // Expected values from the stimulus table
    input  logic               check_i,
    input  logic [3:0]         exp_outs_i,
    input  mci_pkg::csr_data_t exp_rdata_i,

    output int                 test_cnt_o,
    output int                 fail_cnt_o
);

    int   test_cnt = 0;
    int   fail_cnt = 0;
    logic row_bad = 1'b0;
    logic rd_prev = 1'b0;

    task compare_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED test %0d %s got 0x%08h expected 0x%08h",
                     test_cnt, name, got, exp);
            row_bad = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // Compare on the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_i) begin
            // Read return is due exactly one cycle after the strobe
            compare_val("csr_rvalid_o", {31'd0, csr_rvalid_i}, {31'd0, rd_prev});
            rd_prev = csr_rd_i;
            // Read data is compared on the cycle it is returned
            if (csr_rvalid_i) begin
                compare_val("csr_rdata_o", csr_rdata_i, exp_rdata_i);
            end
            if (check_i) begin
                compare_val("all_error_fatal_o", {31'd0, all_error_fatal_i},
                            {31'd0, exp_outs_i[3]});
                compare_val("all_error_non_fatal_o", {31'd0, all_error_non_fatal_i},
                            {31'd0, exp_outs_i[2]});
                compare_val("mci_intr_o", {31'd0, mci_intr_i}, {31'd0, exp_outs_i[1]});
                compare_val("nmi_intr_o", {31'd0, nmi_intr_i}, {31'd0, exp_outs_i[0]});
                if (row_bad) begin
                    fail_cnt = fail_cnt + 1;
                end else begin
                    $display("test %0d passed", test_cnt);
                end
                test_cnt = test_cnt + 1;
                row_bad  = 1'b0;
            end
        end
    end

    assign test_cnt_o = test_cnt;
    assign fail_cnt_o = fail_cnt;

endmodule

/* tb_mci_top.sv */
// Uses watchdog periods of 40 and 30 cycles and random error patterns from a fixed seed
`timescale 1ns/1ps

module tb_mci_top;

    import mci_pkg::*;

    localparam int T1_PERIOD = 40;
    localparam int T2_PERIOD = 30;

    typedef enum logic [2:0] {
        OP_WR,
        OP_RD,
        OP_ERR_F,
        OP_ERR_NF,
        OP_WAIT
    } op_e;

    // Where a row takes its data or expected read value from
    typedef enum logic [1:0] {
        SEL_LIT,
        SEL_FPAT,
        SEL_NPAT
    } sel_e;

    // exp_outs is {all_error_fatal, all_error_non_fatal, mci_intr, nmi_intr}
    typedef struct packed {
        op_e        op;
        csr_addr_t  addr;
        csr_data_t  data;
        sel_e       sel;
        logic [7:0] wait_cyc;
        logic [3:0] exp_outs;
        csr_data_t  exp_rdata;
    } row_t;

    logic       clk;
    logic       rst_i;
    logic       csr_wr;
    logic       csr_rd;
    csr_addr_t  csr_addr;
    csr_data_t  csr_wdata;
    logic       csr_rvalid;
    csr_data_t  csr_rdata;
    err_vec_t   agg_fatal;
    err_vec_t   agg_non_fatal;
    logic       all_fatal;
    logic       all_non_fatal;
    logic       mci_intr;
    logic       nmi_intr;
    logic       check_req;
    logic [3:0] exp_outs;
    csr_data_t  exp_rdata;
    int         test_cnt;
    int         fail_cnt;
    int         cycle_cnt = 0;
    int         cycle_limit = 1000;
    row_t       rows[$];
    logic [31:0] rng;
    err_vec_t   fpat;
    err_vec_t   npat;

    mci_top #(
        .NUM_ERR       (32),
        .WDT_CNT_WIDTH (32)
    ) uut (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .csr_wr_i              (csr_wr),
        .csr_rd_i              (csr_rd),
        .csr_addr_i            (csr_addr),
        .csr_wdata_i           (csr_wdata),
        .csr_rvalid_o          (csr_rvalid),
        .csr_rdata_o           (csr_rdata),
        .agg_error_fatal_i     (agg_fatal),
        .agg_error_non_fatal_i (agg_non_fatal),
        .all_error_fatal_o     (all_fatal),
        .all_error_non_fatal_o (all_non_fatal),
        .mci_intr_o            (mci_intr),
        .nmi_intr_o            (nmi_intr)
    );

    tb_mci_checker i_checker (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .csr_rd_i              (csr_rd),
        .csr_rvalid_i          (csr_rvalid),
        .csr_rdata_i           (csr_rdata),
        .all_error_fatal_i     (all_fatal),
        .all_error_non_fatal_i (all_non_fatal),
        .mci_intr_i            (mci_intr),
        .nmi_intr_i            (nmi_intr),
        .check_i               (check_req),
        .exp_outs_i            (exp_outs),
        .exp_rdata_i           (exp_rdata),
        .test_cnt_o            (test_cnt),
        .fail_cnt_o            (fail_cnt)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic csr_data_t pick_value(input sel_e sel, input csr_data_t lit);
        case (sel)
            SEL_FPAT: return fpat;
            SEL_NPAT: return npat;
            default:  return lit;
        endcase
    endfunction

    task automatic add_row(input op_e op, input csr_addr_t addr, input csr_data_t data,
                           input sel_e sel, input int wait_cyc, input logic [3:0] outs,
                           input csr_data_t rdata);
        row_t r;
        r.op        = op;
        r.addr      = addr;
        r.data      = data;
        r.sel       = sel;
        r.wait_cyc  = 8'(wait_cyc);
        r.exp_outs  = outs;
        r.exp_rdata = rdata;
        rows.push_back(r);
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    task automatic build_table();
        int a;
        // Reset values
        for (a = 0; a < 10; a++) begin
            add_row(OP_RD, csr_addr_t'(a), 32'd0, SEL_LIT, 0, 4'b0000, 32'd0);
        end
        // Fatal capture, W1C and masking
        add_row(OP_ERR_F, 4'd0, 32'd0, SEL_FPAT, 0, 4'b1000, 32'd0);
        add_row(OP_RD, ADDR_ERR_FATAL_STS, 32'd0, SEL_FPAT, 0, 4'b1000, 32'd0);
        add_row(OP_WR, ADDR_ERR_FATAL_STS, 32'd0, SEL_FPAT, 2, 4'b0000, 32'd0);
        add_row(OP_WR, ADDR_ERR_FATAL_MASK, 32'd0, SEL_FPAT, 1, 4'b0000, 32'd0);
        add_row(OP_ERR_F, 4'd0, 32'd0, SEL_FPAT, 2, 4'b0000, 32'd0);
        add_row(OP_RD, ADDR_ERR_FATAL_STS, 32'd0, SEL_FPAT, 0, 4'b0000, 32'd0);
        add_row(OP_WR, ADDR_ERR_FATAL_MASK, 32'd0, SEL_LIT, 2, 4'b1000, 32'd0);
        add_row(OP_WR, ADDR_ERR_FATAL_STS, 32'd0, SEL_FPAT, 2, 4'b0000, 32'd0);
        add_row(OP_RD, ADDR_ERR_FATAL_STS, 32'd0, SEL_LIT, 0, 4'b0000, 32'd0);
        // Non-fatal and the interrupt enables
        add_row(OP_ERR_NF, 4'd0, 32'd0, SEL_NPAT, 0, 4'b0100, 32'd0);
        add_row(OP_RD, ADDR_ERR_NONFATAL_STS, 32'd0, SEL_NPAT, 0, 4'b0100, 32'd0);
        add_row(OP_WR, ADDR_INTR_EN, 32'd2, SEL_LIT, 2, 4'b0100, 32'd0);
        add_row(OP_WR, ADDR_INTR_EN, 32'd4, SEL_LIT, 2, 4'b0100, 32'd0);
        add_row(OP_WR, ADDR_INTR_EN, 32'd6, SEL_LIT, 2, 4'b0110, 32'd0);
        add_row(OP_WR, ADDR_ERR_NONFATAL_STS, 32'd0, SEL_NPAT, 2, 4'b0000, 32'd0);
        // Watchdog first stage and restart
        add_row(OP_WR, ADDR_INTR_EN, 32'd5, SEL_LIT, 1, 4'b0000, 32'd0);
        add_row(OP_WR, ADDR_WDT_T1_PERIOD, T1_PERIOD, SEL_LIT, 0, 4'b0000, 32'd0);
        add_row(OP_WR, ADDR_WDT_T2_PERIOD, T2_PERIOD, SEL_LIT, 0, 4'b0000, 32'd0);
        add_row(OP_WR, ADDR_WDT_CTRL, 32'd1, SEL_LIT, T1_PERIOD + 10, 4'b0010, 32'd0);
        add_row(OP_RD, ADDR_WDT_STS, 32'd0, SEL_LIT, 0, 4'b0010, 32'd1);
        add_row(OP_WR, ADDR_WDT_RESTART, 32'd1, SEL_LIT, 2, 4'b0000, 32'd0);
        add_row(OP_RD, ADDR_WDT_STS, 32'd0, SEL_LIT, 0, 4'b0000, 32'd0);
        // Cascade into the fatal timeout, which a restart leaves set
        add_row(OP_WAIT, 4'd0, 32'd0, SEL_LIT, T1_PERIOD + 10, 4'b0010, 32'd0);
        add_row(OP_WAIT, 4'd0, 32'd0, SEL_LIT, T2_PERIOD + 10, 4'b1011, 32'd0);
        add_row(OP_RD, ADDR_WDT_STS, 32'd0, SEL_LIT, 0, 4'b1011, 32'd3);
        add_row(OP_WR, ADDR_WDT_RESTART, 32'd1, SEL_LIT, 2, 4'b1001, 32'd0);
        add_row(OP_RD, ADDR_WDT_STS, 32'd0, SEL_LIT, 0, 4'b1001, 32'd2);
    endtask

    task automatic apply_row(input row_t r);
        csr_data_t val;
        val = pick_value(r.sel, (r.op == OP_RD) ? r.exp_rdata : r.data);
        @(posedge clk);
        check_req <= 1'b0;
        case (r.op)
            OP_WR: begin
                csr_wr    <= 1'b1;
                csr_addr  <= r.addr;
                csr_wdata <= val;
            end
            OP_RD: begin
                csr_rd    <= 1'b1;
                csr_addr  <= r.addr;
                exp_rdata <= val;
            end
            OP_ERR_F:  agg_fatal     <= val;
            OP_ERR_NF: agg_non_fatal <= val;
            default: begin
            end
        endcase
        @(posedge clk);
        csr_wr        <= 1'b0;
        csr_rd        <= 1'b0;
        agg_fatal     <= '0;
        agg_non_fatal <= '0;
        // Read return handshake, bounded by the cycle counter
        if (r.op == OP_RD) begin
            @(negedge clk);
            while (!csr_rvalid) begin
                @(negedge clk);
            end
        end
        repeat (r.wait_cyc) @(posedge clk);
        @(posedge clk);
        exp_outs  <= r.exp_outs;
        check_req <= 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        rst_i         <= 1'b1;
        csr_wr        <= 1'b0;
        csr_rd        <= 1'b0;
        csr_addr      <= '0;
        csr_wdata     <= '0;
        agg_fatal     <= '0;
        agg_non_fatal <= '0;
        check_req     <= 1'b0;
        exp_outs      <= '0;
        exp_rdata     <= '0;
        rng  = next_random(32'hfe233fba);
        fpat = rng;
        rng  = next_random(rng);
        npat = rng;
        build_table();
        cycle_limit = 200;
        foreach (rows[i]) begin
            cycle_limit = cycle_limit + int'(rows[i].wait_cyc);
        end
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        @(posedge clk);
        check_req <= 1'b0;
        @(negedge clk);
        $display("tests run %0d, tests failed %0d", test_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

endmodule

/* verilog.f */
mci_pkg.sv
mci_csr.sv
mci_wdt.sv
mci_err_agg.sv
mci_intr_comb.sv
mci_top.sv
tb_mci_checker.sv
tb_mci_top.sv
